//--- common/bgpu_pkg.sv
// ############################
// BGPU shared definitions
// Widths, typedefs and slot states of the issue stage
// ############################

package bgpu_pkg;

    // ############################
    // Sizes
    // ############################

    // Warps per compute unit
    localparam int unsigned NUM_WARPS         = 4;
    // In-flight instructions per warp
    localparam int unsigned NUM_TAGS          = 4;
    // Buffered instructions per warp
    localparam int unsigned WAIT_BUF_SIZE     = 2;
    localparam int unsigned PC_WIDTH          = 16;
    // Threads per warp
    localparam int unsigned WARP_WIDTH        = 8;
    localparam int unsigned REG_IDX_WIDTH     = 4;
    localparam int unsigned OPERANDS_PER_INST = 2;
    localparam int unsigned INST_WIDTH        = 8;
    localparam int unsigned WID_WIDTH         = 2;
    localparam int unsigned TAG_WIDTH         = 2;
    // Warp id sits above the tag
    localparam int unsigned IID_WIDTH         = 4;
    // Wait buffer slot index
    localparam int unsigned WB_IDX_WIDTH      = $clog2(WAIT_BUF_SIZE);

    // ############################
    // Types
    // ############################

    typedef logic [WID_WIDTH-1:0]     wid_t;
    typedef logic [TAG_WIDTH-1:0]     tag_t;
    typedef logic [IID_WIDTH-1:0]     iid_t;
    typedef logic [PC_WIDTH-1:0]      pc_t;
    typedef logic [WARP_WIDTH-1:0]    act_mask_t;
    typedef logic [INST_WIDTH-1:0]    bgpu_inst_t;
    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
    typedef logic [WB_IDX_WIDTH-1:0]  wb_idx_t;
    // One flag per operand
    typedef logic [OPERANDS_PER_INST-1:0] op_req_t;
    // Operand 0 in the low bits
    typedef logic [OPERANDS_PER_INST*REG_IDX_WIDTH-1:0] operands_t;

    // One buffered instruction, 46 bits
    typedef struct packed {
        pc_t        pc;
        act_mask_t  act_mask;
        bgpu_inst_t inst;
        reg_idx_t   dst;
        op_req_t    op_req;
        operands_t  operands;
    } disp_data_t;

    // Wait buffer slot life cycle
    typedef enum logic [1:0] {
        EMPTY,
        RESERVED,
        FULL
    } slot_state_e;

endpackage

//--- design/dispatcher/scoreboard.sv
// ############################
// Scoreboard
// Per-warp in-flight tags, hazard check and tag allocation
// ############################

`timescale 1ns/1ps

module scoreboard (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    // Allocation on dispatch
    input  logic                 alloc_i,
    input  bgpu_pkg::reg_idx_t   alloc_dst_i,
    // Completion from execution units
    input  logic                 release_i,
    input  bgpu_pkg::tag_t       release_tag_i,
    // Instruction under check
    input  bgpu_pkg::reg_idx_t   chk_dst_i,
    input  bgpu_pkg::op_req_t    chk_op_req_i,
    input  bgpu_pkg::operands_t  chk_operands_i,
    output logic                 hazard_o,
    output bgpu_pkg::tag_t       free_tag_o,
    output logic                 tag_avail_o
);
    import bgpu_pkg::*;

    // Tag table
    logic     [NUM_TAGS-1:0] valid_q;
    reg_idx_t                dst_q [NUM_TAGS];

    // Tag offered on the previous cycle
    tag_t offer_q;
    tag_t lowest_free;

    // ############################
    // Hazard check
    // ############################

    always_comb begin
        hazard_o = 1'b0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            // WAW on the destination
            if (valid_q[t] && (dst_q[t] == chk_dst_i)) begin
                hazard_o = 1'b1;
            end
            // RAW on each required operand
            for (int o = 0; o < OPERANDS_PER_INST; o++) begin
                if (valid_q[t] && chk_op_req_i[o] &&
                    (chk_operands_i[o*REG_IDX_WIDTH +: REG_IDX_WIDTH] == dst_q[t])) begin
                    hazard_o = 1'b1;
                end
            end
        end
    end

    // ############################
    // Tag selection
    // ############################

    // Priority search, lowest index wins
    always_comb begin
        lowest_free = '0;
        for (int t = NUM_TAGS - 1; t >= 0; t--) begin
            if (!valid_q[t]) begin
                lowest_free = tag_t'(t);
            end
        end
    end

    // An offered tag stays put while it is free
    // so a release never moves a pending offer
    assign free_tag_o  = valid_q[offer_q] ? lowest_free : offer_q;
    assign tag_avail_o = ~&valid_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            offer_q <= '0;
        end else begin
            offer_q <= free_tag_o;
            if (release_i) begin
                valid_q[release_tag_i] <= 1'b0;
            end
            // Allocate the offered tag
            if (alloc_i) begin
                valid_q[free_tag_o] <= 1'b1;
            end
        end
    end

    // Destination register per tag
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            dst_q[free_tag_o] <= alloc_dst_i;
        end
    end

endmodule

//--- design/dispatcher/dispatcher.sv
// ############################
// Dispatcher
// Per-warp wait buffer, reservation and in-order issue
// ############################

`timescale 1ns/1ps

module dispatcher (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    // Fetcher reservation
    input  logic                 fe_handshake_i,
    output logic                 ib_space_available_o,
    // Decoder valid/ready
    input  logic                 dec_valid_i,
    input  bgpu_pkg::disp_data_t dec_data_i,
    output logic                 dec_ready_o,
    // Towards the arbiter
    input  logic                 gnt_i,
    output logic                 req_o,
    output bgpu_pkg::disp_data_t disp_data_o,
    output bgpu_pkg::tag_t       disp_tag_o,
    // Completion for this warp
    input  logic                 eu_valid_i,
    input  bgpu_pkg::tag_t       eu_tag_i
);
    import bgpu_pkg::*;

    // Circular wait buffer
    slot_state_e slot_state_q [WAIT_BUF_SIZE];
    disp_data_t  data_q       [WAIT_BUF_SIZE];

    // Head issues, tail takes the next reservation
    wb_idx_t head_q;
    wb_idx_t tail_q;
    // Oldest reserved slot
    wb_idx_t fill_idx;

    logic fe_fire;
    logic dec_fire;
    logic disp_fire;
    logic head_full;

    // Scoreboard view of the head
    logic hazard;
    logic tag_avail;

    // Step a slot index with wraparound
    function automatic wb_idx_t wrap_inc(wb_idx_t idx);
        if (int'(idx) == WAIT_BUF_SIZE - 1) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    // ############################
    // Buffer status
    // ############################

    // Free slot always sits at the tail
    assign ib_space_available_o = (slot_state_q[tail_q] == EMPTY);

    // Search from the head for the first reserved slot
    always_comb begin
        fill_idx    = head_q;
        dec_ready_o = 1'b0;
        for (int i = WAIT_BUF_SIZE - 1; i >= 0; i--) begin
            if (slot_state_q[wb_idx_t'((int'(head_q) + i) % WAIT_BUF_SIZE)] == RESERVED) begin
                fill_idx    = wb_idx_t'((int'(head_q) + i) % WAIT_BUF_SIZE);
                dec_ready_o = 1'b1;
            end
        end
    end

    assign fe_fire   = fe_handshake_i && ib_space_available_o;
    assign dec_fire  = dec_valid_i && dec_ready_o;
    assign head_full = (slot_state_q[head_q] == FULL);

    // ############################
    // Issue control
    // ############################

    // Head only, in order
    assign req_o       = head_full && !hazard && tag_avail;
    assign disp_fire   = req_o && gnt_i;
    assign disp_data_o = data_q[head_q];

    scoreboard i_scoreboard (
        .clk_i          ( clk_i                   ),
        .arst_n_i       ( arst_n_i                ),
        .alloc_i        ( disp_fire               ),
        .alloc_dst_i    ( data_q[head_q].dst      ),
        .release_i      ( eu_valid_i              ),
        .release_tag_i  ( eu_tag_i                ),
        .chk_dst_i      ( data_q[head_q].dst      ),
        .chk_op_req_i   ( data_q[head_q].op_req   ),
        .chk_operands_i ( data_q[head_q].operands ),
        .hazard_o       ( hazard                  ),
        .free_tag_o     ( disp_tag_o              ),
        .tag_avail_o    ( tag_avail               )
    );

    // ############################
    // Slot state and pointers
    // ############################

    // Fetch, fill and issue always touch different slots
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q <= '0;
            tail_q <= '0;
            for (int i = 0; i < WAIT_BUF_SIZE; i++) begin
                slot_state_q[i] <= EMPTY;
            end
        end else begin
            if (fe_fire) begin
                slot_state_q[tail_q] <= RESERVED;
                tail_q               <= wrap_inc(tail_q);
            end
            if (dec_fire) begin
                slot_state_q[fill_idx] <= FULL;
            end
            if (disp_fire) begin
                slot_state_q[head_q] <= EMPTY;
                head_q               <= wrap_inc(head_q);
            end
        end
    end

    // Instruction payload
    always_ff @(posedge clk_i) begin
        if (dec_fire) begin
            data_q[fill_idx] <= dec_data_i;
        end
    end

endmodule

//--- design/rr_arbiter.sv
// ############################
// Round-robin arbiter
// Shares the dispatch port, locks the winner under back-pressure
// ############################

`timescale 1ns/1ps

module rr_arbiter (
    input  logic                                           clk_i,
    input  logic                                           arst_n_i,
    input  logic                 [bgpu_pkg::NUM_WARPS-1:0] req_i,
    input  bgpu_pkg::disp_data_t [bgpu_pkg::NUM_WARPS-1:0] data_i,
    input  bgpu_pkg::tag_t       [bgpu_pkg::NUM_WARPS-1:0] tag_i,
    input  logic                                           ready_i,
    output logic                 [bgpu_pkg::NUM_WARPS-1:0] gnt_o,
    output logic                                           valid_o,
    output bgpu_pkg::disp_data_t                           data_o,
    output bgpu_pkg::iid_t                                 iid_o
);
    import bgpu_pkg::*;

    // Priority pointer and lock
    wid_t ptr_q;
    logic lock_q;
    wid_t lock_idx_q;

    wid_t search_idx;
    wid_t win_idx;

    // First requester at or above the pointer
    always_comb begin
        search_idx = ptr_q;
        for (int i = NUM_WARPS - 1; i >= 0; i--) begin
            if (req_i[wid_t'((int'(ptr_q) + i) % NUM_WARPS)]) begin
                search_idx = wid_t'((int'(ptr_q) + i) % NUM_WARPS);
            end
        end
    end

    // Held winner keeps its request up
    assign win_idx = lock_q ? lock_idx_q : search_idx;
    assign valid_o = |req_i;
    assign data_o  = data_i[win_idx];
    assign iid_o   = {win_idx, tag_i[win_idx]};

    always_comb begin
        gnt_o          = '0;
        gnt_o[win_idx] = valid_o && ready_i;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q      <= '0;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else begin
            lock_q     <= valid_o && !ready_i;
            lock_idx_q <= win_idx;
            // Next round starts past the winner
            if (valid_o && ready_i) begin
                ptr_q <= (int'(win_idx) == NUM_WARPS - 1) ? '0 : win_idx + 1'b1;
            end
        end
    end

endmodule

//--- design/multi_warp_dispatcher.sv
// ############################
// Multi-warp dispatcher
// One dispatcher per warp sharing one dispatch port
// ############################

`timescale 1ns/1ps

module multi_warp_dispatcher (
    input  logic                                         clk_i,
    input  logic                                         arst_n_i,
    // Fetcher
    input  logic                                         fe_handshake_i,
    input  bgpu_pkg::wid_t                               fe_warp_id_i,
    output logic               [bgpu_pkg::NUM_WARPS-1:0] ib_space_available_o,
    // Decoder
    output logic                                         ib_ready_o,
    input  logic                                         dec_valid_i,
    input  bgpu_pkg::pc_t                                dec_pc_i,
    input  bgpu_pkg::act_mask_t                          dec_act_mask_i,
    input  bgpu_pkg::wid_t                               dec_warp_id_i,
    input  bgpu_pkg::bgpu_inst_t                         dec_inst_i,
    input  bgpu_pkg::reg_idx_t                           dec_dst_i,
    input  bgpu_pkg::op_req_t                            dec_operands_required_i,
    input  bgpu_pkg::operands_t                          dec_operands_i,
    // Operand collector
    input  logic                                         opc_ready_i,
    output logic                                         disp_valid_o,
    output bgpu_pkg::iid_t                               disp_tag_o,
    output bgpu_pkg::pc_t                                disp_pc_o,
    output bgpu_pkg::act_mask_t                          disp_act_mask_o,
    output bgpu_pkg::bgpu_inst_t                         disp_inst_o,
    output bgpu_pkg::reg_idx_t                           disp_dst_o,
    output bgpu_pkg::op_req_t                            disp_operands_required_o,
    output bgpu_pkg::operands_t                          disp_operands_o,
    // Execution units
    input  logic                                         eu_valid_i,
    input  bgpu_pkg::iid_t                               eu_tag_i
);
    import bgpu_pkg::*;

    // ############################
    // Per-warp signals
    // ############################

    logic [NUM_WARPS-1:0] fe_handshake_warp;
    logic [NUM_WARPS-1:0] dec_valid_warp;
    logic [NUM_WARPS-1:0] dec_ready_warp;
    logic [NUM_WARPS-1:0] eu_valid_warp;
    logic [NUM_WARPS-1:0] req_warp;
    logic [NUM_WARPS-1:0] gnt_warp;

    disp_data_t [NUM_WARPS-1:0] data_warp;
    tag_t       [NUM_WARPS-1:0] tag_warp;

    // Decoder fields as one record
    disp_data_t dec_data;
    disp_data_t arb_data;

    assign dec_data = '{
        pc:       dec_pc_i,
        act_mask: dec_act_mask_i,
        inst:     dec_inst_i,
        dst:      dec_dst_i,
        op_req:   dec_operands_required_i,
        operands: dec_operands_i
    };

    // Demux by warp id, completions by the iid's upper bits
    always_comb begin
        fe_handshake_warp = '0;
        dec_valid_warp    = '0;
        eu_valid_warp     = '0;
        fe_handshake_warp[fe_warp_id_i]                      = fe_handshake_i;
        dec_valid_warp[dec_warp_id_i]                        = dec_valid_i;
        eu_valid_warp[eu_tag_i[IID_WIDTH-1 -: WID_WIDTH]]    = eu_valid_i;
    end

    // Ready of the addressed warp
    assign ib_ready_o = dec_ready_warp[dec_warp_id_i];

    for (genvar w = 0; w < NUM_WARPS; w++) begin : gen_dispatcher
        dispatcher i_dispatcher (
            .clk_i                ( clk_i                   ),
            .arst_n_i             ( arst_n_i                ),
            .fe_handshake_i       ( fe_handshake_warp[w]    ),
            .ib_space_available_o ( ib_space_available_o[w] ),
            .dec_valid_i          ( dec_valid_warp[w]       ),
            .dec_data_i           ( dec_data                ),
            .dec_ready_o          ( dec_ready_warp[w]       ),
            .gnt_i                ( gnt_warp[w]             ),
            .req_o                ( req_warp[w]             ),
            .disp_data_o          ( data_warp[w]            ),
            .disp_tag_o           ( tag_warp[w]             ),
            .eu_valid_i           ( eu_valid_warp[w]        ),
            .eu_tag_i             ( eu_tag_i[TAG_WIDTH-1:0] )
        );
    end

    // ############################
    // Dispatch port
    // ############################

    rr_arbiter i_rr_arbiter (
        .clk_i    ( clk_i        ),
        .arst_n_i ( arst_n_i     ),
        .req_i    ( req_warp     ),
        .data_i   ( data_warp    ),
        .tag_i    ( tag_warp     ),
        .ready_i  ( opc_ready_i  ),
        .gnt_o    ( gnt_warp     ),
        .valid_o  ( disp_valid_o ),
        .data_o   ( arb_data     ),
        .iid_o    ( disp_tag_o   )
    );

    // Unpack towards the operand collector
    assign disp_pc_o                = arb_data.pc;
    assign disp_act_mask_o          = arb_data.act_mask;
    assign disp_inst_o              = arb_data.inst;
    assign disp_dst_o               = arb_data.dst;
    assign disp_operands_required_o = arb_data.op_req;
    assign disp_operands_o          = arb_data.operands;

endmodule

//--- dv/multi_warp_dispatcher_props.sv
// ############################
// Dispatch port properties
// Back-pressure, reset and fetch rules
// ############################

`timescale 1ns/1ps

module multi_warp_dispatcher_props (
    input logic                                         clk_i,
    input logic                                         arst_n_i,
    input logic                                         fe_handshake_i,
    input bgpu_pkg::wid_t                               fe_warp_id_i,
    input logic               [bgpu_pkg::NUM_WARPS-1:0] ib_space_available_o,
    input logic                                         opc_ready_i,
    input logic                                         disp_valid_o,
    input bgpu_pkg::iid_t                               disp_tag_o,
    input bgpu_pkg::pc_t                                disp_pc_o,
    input bgpu_pkg::act_mask_t                          disp_act_mask_o,
    input bgpu_pkg::bgpu_inst_t                         disp_inst_o,
    input bgpu_pkg::reg_idx_t                           disp_dst_o,
    input bgpu_pkg::op_req_t                            disp_operands_required_o,
    input bgpu_pkg::operands_t                          disp_operands_o
);

    // Failed properties so far
    int unsigned fail_cnt = 0;

    // Offer held until the collector takes it
    a_disp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        disp_valid_o && !opc_ready_i |=> disp_valid_o &&
        $stable({disp_tag_o, disp_pc_o, disp_act_mask_o, disp_inst_o, disp_dst_o,
                 disp_operands_required_o, disp_operands_o}))
    else begin
        fail_cnt++;
        $error("dispatch outputs changed under back-pressure");
    end

    a_reset_idle: assert property (@(posedge clk_i) !arst_n_i |-> !disp_valid_o)
    else begin
        fail_cnt++;
        $error("disp_valid_o high during reset");
    end

    // Fetch only into a warp with room
    a_fetch_space: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        fe_handshake_i |-> ib_space_available_o[fe_warp_id_i])
    else begin
        fail_cnt++;
        $error("fetch handshake for a warp without space");
    end

endmodule

bind multi_warp_dispatcher multi_warp_dispatcher_props i_props (.*);

//--- dv/tb_multi_warp_dispatcher.sv
// ############################
// Multi-warp dispatcher testbench
// Directed tests of issue order, hazards, tags and arbitration
// ############################

`timescale 1ns/1ps

module tb_multi_warp_dispatcher;

    // About five times the length of all tests
    localparam int TIMEOUT_CYCLES = 2000;

    // One dispatch as seen on the collector port
    typedef struct packed {
        logic [3:0]  iid;
        logic [15:0] pc;
        logic [7:0]  mask;
        logic [7:0]  inst;
        logic [3:0]  dst;
        logic [1:0]  op_req;
        logic [7:0]  operands;
    } rec_t;

    logic        clk_i = 1'b0;
    logic        arst_n_i;
    logic        fe_handshake_i;
    logic [1:0]  fe_warp_id_i;
    logic [3:0]  ib_space_available_o;
    logic        ib_ready_o;
    logic        dec_valid_i;
    logic [15:0] dec_pc_i;
    logic [7:0]  dec_act_mask_i;
    logic [1:0]  dec_warp_id_i;
    logic [7:0]  dec_inst_i;
    logic [3:0]  dec_dst_i;
    logic [1:0]  dec_operands_required_i;
    logic [7:0]  dec_operands_i;
    logic        opc_ready_i;
    logic        disp_valid_o;
    logic [3:0]  disp_tag_o;
    logic [15:0] disp_pc_o;
    logic [7:0]  disp_act_mask_o;
    logic [7:0]  disp_inst_o;
    logic [3:0]  disp_dst_o;
    logic [1:0]  disp_operands_required_o;
    logic [7:0]  disp_operands_o;
    logic        eu_valid_i;
    logic [3:0]  eu_tag_i;

    logic [31:0] lcg_state = 32'h25cf_c5c0;
    int          cycle_cnt = 0;
    // Expected instruction per iid
    rec_t        exp_rec [16];
    rec_t        seen_q [$];

    always #20 clk_i = ~clk_i;

    multi_warp_dispatcher UUT (.*);

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1, "Simulation stopped on timeout");
        end
    end

    // Bound property failures end the run at once
    always @(negedge clk_i) begin
        if (UUT.i_props.fail_cnt != 0) begin
            $display("A dispatch port property failed before time %0t", $time);
            $display("Test failed");
            $fatal(1, "Stopped at the first property failure");
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic rec_t current_disp();
        return {disp_tag_o, disp_pc_o, disp_act_mask_o, disp_inst_o, disp_dst_o,
                disp_operands_required_o, disp_operands_o};
    endfunction

    // Handshakes sampled mid-cycle, consumed by the tests at the edge
    always @(negedge clk_i) begin
        if (arst_n_i && disp_valid_o && opc_ready_i) begin
            seen_q.push_back(current_disp());
        end
    end

    // ############################
    // Checker and drivers
    // ############################

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("Fail at time %0t: %s is %0h, expected %0h", $time, name, got, expected);
            $display("Test failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic compare_rec(input rec_t got, input rec_t expected);
        check_value("disp_tag_o", got.iid, expected.iid);
        check_value("disp_pc_o", got.pc, expected.pc);
        check_value("disp_act_mask_o", got.mask, expected.mask);
        check_value("disp_inst_o", got.inst, expected.inst);
        check_value("disp_dst_o", got.dst, expected.dst);
        check_value("disp_operands_required_o", got.op_req, expected.op_req);
        check_value("disp_operands_o", got.operands, expected.operands);
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        arst_n_i    <= 1'b0;
        opc_ready_i <= 1'b1;
        // Nothing left over from the previous test
        check_value("count of unexpected dispatches", seen_q.size(), 0);
        repeat (2) @(posedge clk_i);
        arst_n_i <= 1'b1;
    endtask

    task automatic fetch(input logic [1:0] w);
        do begin
            @(negedge clk_i);
        end while (!ib_space_available_o[w]);
        @(posedge clk_i);
        fe_handshake_i <= 1'b1;
        fe_warp_id_i   <= w;
        @(posedge clk_i);
        fe_handshake_i <= 1'b0;
    endtask

    // Fields held until ready, transfer on the following edge
    task automatic decode(input logic [1:0] w, input rec_t rec);
        @(posedge clk_i);
        dec_valid_i             <= 1'b1;
        dec_warp_id_i           <= w;
        dec_pc_i                <= rec.pc;
        dec_act_mask_i          <= rec.mask;
        dec_inst_i              <= rec.inst;
        dec_dst_i               <= rec.dst;
        dec_operands_required_i <= rec.op_req;
        dec_operands_i          <= rec.operands;
        do begin
            @(negedge clk_i);
        end while (!ib_ready_o);
        @(posedge clk_i);
        dec_valid_i <= 1'b0;
    endtask

    task automatic complete(input logic [3:0] iid);
        @(posedge clk_i);
        eu_valid_i <= 1'b1;
        eu_tag_i   <= iid;
        @(posedge clk_i);
        eu_valid_i <= 1'b0;
    endtask

    // Random pc, mask and opcode, expected under the tag it should get
    task automatic send(input logic [1:0] w, input logic [1:0] tag, input logic [3:0] dst,
                        input logic [1:0] op_req, input logic [7:0] operands);
        logic [31:0] rnd;
        rnd = lcg_next();
        exp_rec[{w, tag}] = {w, tag, rnd[31:16], rnd[15:8], rnd[7:0], dst, op_req, operands};
        decode(w, exp_rec[{w, tag}]);
    endtask

    task automatic expect_dispatch(input logic [3:0] iid);
        while (seen_q.size() == 0) begin
            @(posedge clk_i);
        end
        compare_rec(seen_q.pop_front(), exp_rec[iid]);
    endtask

    task automatic hold_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            check_value("disp_valid_o", disp_valid_o, 1'b0);
        end
    endtask

    task automatic hold_valid(input logic [3:0] iid, input int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            check_value("disp_valid_o", disp_valid_o, 1'b1);
            compare_rec(current_disp(), exp_rec[iid]);
        end
    endtask

    // ############################
    // Directed tests
    // ############################

    task automatic test_single_dispatch();
        apply_reset();
        fetch(2'd2);
        send(2'd2, 2'd0, 4'd3, 2'b11, 8'h65);
        expect_dispatch(4'h8);
        hold_idle(3);
    endtask

    task automatic test_space_and_ready();
        apply_reset();
        @(posedge clk_i);
        dec_warp_id_i <= 2'd1;
        @(negedge clk_i);
        check_value("ib_space_available_o", ib_space_available_o, 4'hf);
        check_value("ib_ready_o", ib_ready_o, 1'b0);
        fetch(2'd1);
        fetch(2'd1);
        @(negedge clk_i);
        check_value("ib_space_available_o", ib_space_available_o, 4'b1101);
        check_value("ib_ready_o", ib_ready_o, 1'b1);
        // Warp 0 holds no reservation
        @(posedge clk_i);
        dec_warp_id_i <= 2'd0;
        @(negedge clk_i);
        check_value("ib_ready_o", ib_ready_o, 1'b0);
        send(2'd1, 2'd0, 4'd2, 2'b00, 8'h00);
        expect_dispatch(4'h4);
        @(negedge clk_i);
        check_value("ib_space_available_o", ib_space_available_o, 4'hf);
    endtask

    task automatic test_raw_hazard();
        apply_reset();
        fetch(2'd3);
        fetch(2'd3);
        send(2'd3, 2'd0, 4'd4, 2'b00, 8'h00);
        // Operand 0 reads r4
        send(2'd3, 2'd1, 4'd7, 2'b01, 8'h24);
        expect_dispatch(4'hc);
        hold_idle(8);
        complete(4'hc);
        expect_dispatch(4'hd);
    endtask

    task automatic test_tag_exhaustion();
        int i;
        apply_reset();
        for (i = 0; i < 4; i++) begin
            fetch(2'd0);
            send(2'd0, 2'(i), 4'(i + 1), 2'b00, 8'h00);
        end
        for (i = 0; i < 4; i++) begin
            expect_dispatch(4'(i));
        end
        // No tag left for the fifth
        fetch(2'd0);
        send(2'd0, 2'd2, 4'd5, 2'b00, 8'h00);
        hold_idle(6);
        complete(4'h2);
        expect_dispatch(4'h2);
    endtask

    task automatic test_round_robin();
        int w;
        int k;
        apply_reset();
        @(posedge clk_i);
        opc_ready_i <= 1'b0;
        for (w = 0; w < 4; w++) begin
            fetch(2'(w));
            fetch(2'(w));
            send(2'(w), 2'd0, 4'd1, 2'b00, 8'h00);
            send(2'(w), 2'd1, 4'd2, 2'b00, 8'h00);
        end
        @(posedge clk_i);
        opc_ready_i <= 1'b1;
        // Second round resumes at warp 0 after warp 3
        for (k = 0; k < 2; k++) begin
            for (w = 0; w < 4; w++) begin
                expect_dispatch({2'(w), 2'(k)});
            end
        end
    endtask

    task automatic test_back_pressure();
        apply_reset();
        @(posedge clk_i);
        opc_ready_i <= 1'b0;
        fetch(2'd1);
        send(2'd1, 2'd0, 4'd6, 2'b10, 8'h31);
        hold_valid(4'h4, 4);
        // Warp 0 is ahead of the pointer yet must not take over
        fetch(2'd0);
        send(2'd0, 2'd0, 4'd6, 2'b00, 8'h00);
        hold_valid(4'h4, 6);
        @(posedge clk_i);
        opc_ready_i <= 1'b1;
        expect_dispatch(4'h4);
        expect_dispatch(4'h0);
    endtask

    initial begin
        arst_n_i                = 1'b1;
        fe_handshake_i          = 1'b0;
        fe_warp_id_i            = '0;
        dec_valid_i             = 1'b0;
        dec_pc_i                = '0;
        dec_act_mask_i          = '0;
        dec_warp_id_i           = '0;
        dec_inst_i              = '0;
        dec_dst_i               = '0;
        dec_operands_required_i = '0;
        dec_operands_i          = '0;
        opc_ready_i             = 1'b1;
        eu_valid_i              = 1'b0;
        eu_tag_i                = '0;
        test_single_dispatch();
        test_space_and_ready();
        test_raw_hazard();
        test_tag_exhaustion();
        test_round_robin();
        test_back_pressure();
        hold_idle(4);
        check_value("count of unexpected dispatches", seen_q.size(), 0);
        if (UUT.i_props.fail_cnt == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "Property failures: %0d", UUT.i_props.fail_cnt);
        end
    end

endmodule

//--- list.f
common/bgpu_pkg.sv
design/dispatcher/scoreboard.sv
design/dispatcher/dispatcher.sv
design/rr_arbiter.sv
design/multi_warp_dispatcher.sv
dv/multi_warp_dispatcher_props.sv
dv/tb_multi_warp_dispatcher.sv
